/* source/acq_defs.svh */
/*
 * ADC capture block build constants
 * Sample packing, buffer geometry and trigger pipeline depth
 */
`ifndef ACQ_DEFS_SVH
`define ACQ_DEFS_SVH

// Sample packing on the input stream
`define ADC_WIDTH       14
`define SLOT_WIDTH      16
`define ADC_SHIFT       (`SLOT_WIDTH - `ADC_WIDTH)
`define LANES           4
`define LANE_SEL_WIDTH  2

// Circular capture buffer, in sample words
`define RAM_DEPTH       64
`define RAM_ADDR_WIDTH  6

// Trigger sources and detection depth
`define EVENT_WIDTH     8
`define DETECT_LATENCY  4

`endif

/* source/acqCfgPkg.sv */
/*
 * Host register layouts for the ADC capture block
 */
`include "acq_defs.svh"

package acqCfgPkg;

    // Control word, start bit or a readback request
    typedef struct packed {
        logic                                          start;
        logic [31-`RAM_ADDR_WIDTH-`LANE_SEL_WIDTH-1:0] spare;
        logic [`RAM_ADDR_WIDTH-1:0]                    readAddress;
        logic [`LANE_SEL_WIDTH-1:0]                    readLane;
    } ctrlReg;

    // Trigger word, level sits left-adjusted in the low half
    typedef struct packed {
        logic [31-16-`EVENT_WIDTH-1:0] spare;
        logic                          fallingEdge;
        logic [`EVENT_WIDTH-1:0]       eventEnables;
        logic signed [`ADC_WIDTH-1:0]  level;
        logic [`ADC_SHIFT-1:0]         levelPad;
    } trigCfg;

    // One bus word, meaning set by the strobe that comes with it
    typedef union packed {
        ctrlReg      ctrl;
        trigCfg      trig;
        logic [31:0] raw;
    } hostWord;

    typedef struct packed {
        logic signed [`ADC_WIDTH-1:0] level;
        logic [`EVENT_WIDTH-1:0]      eventEnables;
        logic                         fallingEdge;
    } trigSettings;

endpackage

/* source/acqDataPkg.sv */
/*
 * Sample, buffer write and capture status types
 */
`include "acq_defs.svh"

package acqDataPkg;

    typedef logic signed [`ADC_WIDTH-1:0] adcSample;

    // All lanes of one clock, lane 0 is the oldest sample
    typedef adcSample [`LANES-1:0] sampleWord;

    typedef struct packed {
        logic                       enable;
        logic [`RAM_ADDR_WIDTH-1:0] address;
        sampleWord                  data;
    } ramWrite;

    typedef enum logic [2:0] {stStart, stFill, stArmed, stAcquire, stDone} acqState;

    typedef struct packed {
        logic                       fired;
        logic [`LANE_SEL_WIDTH-1:0] lane;
        sampleWord                  alignedWord;
    } trigEvent;

endpackage

/* source/acqConfigRegs.sv */
/*
 * Host register file, decodes bus writes into trigger settings,
 * pretrigger length and start or readback pulses
 */
`timescale 1ns/1ps
`include "acq_defs.svh"

module acqConfigRegs (
    input  logic                        adcClk,
    input  logic                        rst,
    input  logic                        csrStrobe,
    input  logic                        trigCfgStrobe,
    input  logic                        pretrigStrobe,
    input  acqCfgPkg::hostWord          hostData,
    output acqCfgPkg::trigSettings      settings,
    output logic [`RAM_ADDR_WIDTH-1:0]  fillLength,
    output logic                        startPulse,
    output logic                        readPulse,
    output logic [`RAM_ADDR_WIDTH-1:0]  readAddress,
    output logic [`LANE_SEL_WIDTH-1:0]  readLane
);

    logic [`RAM_ADDR_WIDTH-1:0] pretrigCount;

    always_ff @(posedge adcClk) begin
        if (rst) begin
            settings     <= '0;
            pretrigCount <= '0;
            startPulse   <= 1'b0;
            readPulse    <= 1'b0;
            readAddress  <= '0;
            readLane     <= '0;
        end else begin
            // A control write either starts a capture or asks for a sample
            startPulse <= csrStrobe && hostData.ctrl.start;
            readPulse  <= csrStrobe && !hostData.ctrl.start;
            if (csrStrobe) begin
                readAddress <= hostData.ctrl.readAddress;
                readLane    <= hostData.ctrl.readLane;
            end
            if (trigCfgStrobe) begin
                settings.level        <= hostData.trig.level;
                settings.eventEnables <= hostData.trig.eventEnables;
                settings.fallingEdge  <= hostData.trig.fallingEdge;
            end
            if (pretrigStrobe) begin
                pretrigCount <= hostData.raw[`RAM_ADDR_WIDTH-1:0];
            end
        end
    end

    // Extra words cover the detector pipeline ahead of the armed state
    assign fillLength = pretrigCount + `RAM_ADDR_WIDTH'(`DETECT_LATENCY - 1);

endmodule

/* source/triggerDetect.sv */
/*
 * Level and event trigger detector, reports the first crossing lane
 * along with the sample word it belongs to
 */
`timescale 1ns/1ps
`include "acq_defs.svh"

module triggerDetect (
    input  logic                                adcClk,
    input  logic                                rst,
    input  logic                                dataValid,
    input  logic [`LANES*`SLOT_WIDTH-1:0]       dataIn,
    input  logic [`EVENT_WIDTH-1:0]             eventStrobes,
    input  acqCfgPkg::trigSettings              settings,
    input  logic                                armed,
    output logic                                alignedValid,
    output acqDataPkg::trigEvent                detectEvent
);

    acqDataPkg::sampleWord word1, word2, word3;
    logic                  valid1, valid2, valid3;
    logic [`LANES-1:0]     above, below, flags;
    logic                  idleSeen, fired;
    logic [`LANE_SEL_WIDTH-1:0] lane;

    // Lowest flagged lane wins
    function automatic logic [`LANE_SEL_WIDTH-1:0] firstLane(input logic [`LANES-1:0] flagBits);
        logic [`LANE_SEL_WIDTH-1:0] sel;
        sel = '0;
        for (int i = `LANES - 1; i >= 0; i--) begin
            if (flagBits[i]) begin
                sel = `LANE_SEL_WIDTH'(i);
            end
        end
        return sel;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Three stage pipeline, extract, compare, pick edge

    always_ff @(posedge adcClk) begin
        if (rst) begin
            valid1 <= 1'b0;
            valid2 <= 1'b0;
            valid3 <= 1'b0;
        end else begin
            valid1 <= dataValid;
            valid2 <= valid1;
            valid3 <= valid2;
        end
    end

    always_ff @(posedge adcClk) begin
        for (int i = 0; i < `LANES; i++) begin
            word1[i] <= dataIn[i*`SLOT_WIDTH+`ADC_SHIFT +: `ADC_WIDTH];
            above[i] <= word1[i] > settings.level;
            below[i] <= word1[i] < settings.level;
        end
        word2 <= word1;
        word3 <= word2;
        flags <= settings.fallingEdge ? below : above;
    end

    //////////////////////////////////////////////////////////////////////
    // Fire decision, needs an idle word first unless an event forces it

    always_ff @(posedge adcClk) begin
        if (rst || !armed) begin
            idleSeen <= 1'b0;
            fired    <= 1'b0;
            lane     <= '0;
        end else if (!fired) begin
            if (|(settings.eventEnables & eventStrobes)) begin
                fired <= 1'b1;
                lane  <= '0;
            end else if (valid3) begin
                if (flags == '0) begin
                    idleSeen <= 1'b1;
                end else if (idleSeen) begin
                    fired <= 1'b1;
                    lane  <= firstLane(flags);
                end
            end
        end
    end

    assign alignedValid = valid3;
    assign detectEvent  = '{fired: fired, lane: lane, alignedWord: word3};

endmodule

/* source/acqSequencer.sv */
/*
 * Capture sequencer, fills the pretrigger region, waits for the
 * trigger and writes the posttrigger remainder of the buffer
 */
`timescale 1ns/1ps
`include "acq_defs.svh"

module acqSequencer (
    input  logic                        adcClk,
    input  logic                        rst,
    input  logic                        startPulse,
    input  logic [`RAM_ADDR_WIDTH-1:0]  fillLength,
    input  logic                        alignedValid,
    input  acqDataPkg::trigEvent        detectEvent,
    output logic                        armed,
    output logic                        active,
    output logic                        full,
    output acqDataPkg::acqState         state,
    output acqDataPkg::ramWrite         ramPort,
    output logic [`RAM_ADDR_WIDTH-1:0]  trigAddress,
    output logic [`LANE_SEL_WIDTH-1:0]  trigLane
);

    localparam logic [`RAM_ADDR_WIDTH-1:0] lastWord = `RAM_ADDR_WIDTH'(`RAM_DEPTH - 1);

    logic                       writeEn;
    logic [`RAM_ADDR_WIDTH-1:0] wrAddr;
    logic [`RAM_ADDR_WIDTH-1:0] wordCount;

    // Active only in the start, fill, armed and acquire states
    assign writeEn = active && alignedValid;
    assign armed   = active && (state == acqDataPkg::stArmed);
    assign ramPort = '{enable: writeEn, address: wrAddr, data: detectEvent.alignedWord};

    always_ff @(posedge adcClk) begin
        if (rst) begin
            state       <= acqDataPkg::stStart;
            active      <= 1'b0;
            full        <= 1'b0;
            wrAddr      <= '0;
            wordCount   <= '0;
            trigAddress <= '0;
            trigLane    <= '0;
        end else begin
            // Circular buffer, address just wraps
            if (writeEn) begin
                wrAddr <= wrAddr + 1'b1;
            end
            if (startPulse) begin
                active    <= 1'b1;
                full      <= 1'b0;
                state     <= acqDataPkg::stStart;
                wordCount <= '0;
            end else if (active) begin
                case (state)
                    acqDataPkg::stStart: begin
                        state <= acqDataPkg::stFill;
                        if (writeEn) begin
                            wordCount <= wordCount + 1'b1;
                        end
                    end
                    acqDataPkg::stFill: begin
                        if (writeEn) begin
                            wordCount <= wordCount + 1'b1;
                            if (wordCount + 1'b1 >= fillLength) begin
                                state <= acqDataPkg::stArmed;
                            end
                        end
                    end
                    acqDataPkg::stArmed: begin
                        // Saturate so a late trigger still leaves one posttrigger word
                        if (writeEn && wordCount != lastWord) begin
                            wordCount <= wordCount + 1'b1;
                        end
                        if (detectEvent.fired) begin
                            // Address the word now entering the detector will take
                            trigAddress <= wrAddr + `RAM_ADDR_WIDTH'(`DETECT_LATENCY - 1);
                            trigLane    <= detectEvent.lane;
                            state       <= acqDataPkg::stAcquire;
                        end
                    end
                    acqDataPkg::stAcquire: begin
                        if (writeEn) begin
                            wordCount <= wordCount + 1'b1;
                            if (wordCount == lastWord) begin
                                state  <= acqDataPkg::stDone;
                                active <= 1'b0;
                                full   <= 1'b1;
                            end
                        end
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

endmodule

/* source/sampleRamArbiter.sv */
/*
 * Single-port sample buffer shared by capture writes and host reads,
 * writes always win and reads wait for a free cycle
 */
`timescale 1ns/1ps
`include "acq_defs.svh"

module sampleRamArbiter (
    input  logic                        adcClk,
    input  logic                        rst,
    input  acqDataPkg::ramWrite         ramPort,
    input  logic                        rdReq,
    input  logic [`RAM_ADDR_WIDTH-1:0]  rdAddress,
    output logic                        rdValid,
    output acqDataPkg::sampleWord       rdData
);

    acqDataPkg::sampleWord mem [`RAM_DEPTH];
    logic                  rdGrant;

    // Read gets the port only when no write is pending
    assign rdGrant = rdReq && !ramPort.enable;

    //////////////////////////////////////////////////////////////////////
    // Memory port, one access per cycle

    always_ff @(posedge adcClk) begin
        if (ramPort.enable) begin
            mem[ramPort.address] <= ramPort.data;
        end else if (rdGrant) begin
            rdData <= mem[rdAddress];
        end
    end

    always_ff @(posedge adcClk) begin
        if (rst) begin
            rdValid <= 1'b0;
        end else begin
            rdValid <= rdGrant;
        end
    end

endmodule

/* source/readoutPort.sv */
/*
 * Host readback, requests one word and returns the chosen lane
 */
`timescale 1ns/1ps
`include "acq_defs.svh"

module readoutPort (
    input  logic                        adcClk,
    input  logic                        rst,
    input  logic                        readPulse,
    input  logic [`RAM_ADDR_WIDTH-1:0]  readAddress,
    input  logic [`LANE_SEL_WIDTH-1:0]  readLane,
    input  logic                        rdValid,
    input  acqDataPkg::sampleWord       rdData,
    output logic                        rdReq,
    output logic [`RAM_ADDR_WIDTH-1:0]  rdAddress,
    output logic [31:0]                 sampleOut
);

    logic pending;

    // Held from the pulse until data comes back
    assign rdReq = readPulse || (pending && !rdValid);

    // Host addresses are in trigger location terms, RAM lags by the detector
    assign rdAddress = readAddress - `RAM_ADDR_WIDTH'(`DETECT_LATENCY);

    always_ff @(posedge adcClk) begin
        if (rst) begin
            pending <= 1'b0;
        end else begin
            pending <= rdReq;
        end
    end

    always_ff @(posedge adcClk) begin
        if (rdValid) begin
            sampleOut <= {{(32-`SLOT_WIDTH){1'b0}}, rdData[readLane], {`ADC_SHIFT{1'b0}}};
        end
    end

endmodule

/* source/acquisitionTop.sv */
/*
 * ADC capture block top level
 * Host registers, trigger detector, sequencer, shared buffer and readback
 */
`timescale 1ns/1ps
`include "acq_defs.svh"

module acquisitionTop (
    input  logic                            adcClk,
    input  logic                            rst,
    input  logic                            csrStrobe,
    input  logic                            trigCfgStrobe,
    input  logic                            pretrigStrobe,
    input  acqCfgPkg::hostWord              hostData,
    input  logic                            dataValid,
    input  logic [`LANES*`SLOT_WIDTH-1:0]   dataIn,
    input  logic [`EVENT_WIDTH-1:0]         eventStrobes,
    output logic [31:0]                     status,
    output logic [31:0]                     sampleOut,
    output logic [31:0]                     triggerLocation
);

    acqCfgPkg::trigSettings     settings;
    logic [`RAM_ADDR_WIDTH-1:0] fillLength, readAddress, rdAddress, trigAddress;
    logic [`LANE_SEL_WIDTH-1:0] readLane, trigLane;
    logic                       startPulse, readPulse, alignedValid, armed;
    logic                       active, full, rdReq, rdValid;
    acqDataPkg::trigEvent       detectEvent;
    acqDataPkg::acqState        state;
    acqDataPkg::ramWrite        ramPort;
    acqDataPkg::sampleWord      rdData;

    acqConfigRegs acqConfigRegs_i (
        .adcClk, .rst, .csrStrobe, .trigCfgStrobe, .pretrigStrobe, .hostData,
        .settings, .fillLength, .startPulse, .readPulse, .readAddress, .readLane
    );

    triggerDetect triggerDetect_i (
        .adcClk, .rst, .dataValid, .dataIn, .eventStrobes, .settings, .armed,
        .alignedValid, .detectEvent
    );

    acqSequencer acqSequencer_i (
        .adcClk, .rst, .startPulse, .fillLength, .alignedValid, .detectEvent,
        .armed, .active, .full, .state, .ramPort, .trigAddress, .trigLane
    );

    sampleRamArbiter sampleRamArbiter_i (
        .adcClk, .rst, .ramPort, .rdReq, .rdAddress, .rdValid, .rdData
    );

    readoutPort readoutPort_i (
        .adcClk, .rst, .readPulse, .readAddress, .readLane, .rdValid, .rdData,
        .rdReq, .rdAddress, .sampleOut
    );

    // Status word, flags on top and sequencer state in the low bits
    assign status = {active, full, {(32-5){1'b0}}, state};
    assign triggerLocation = {{(32-`RAM_ADDR_WIDTH-`LANE_SEL_WIDTH){1'b0}}, trigAddress, trigLane};

endmodule

/* dv/acquisition_chk.sv */
/*
 * Capture checks on the sequencer flags and the shared buffer port
 */
`timescale 1ns/1ps
`include "acq_defs.svh"

module acquisitionChk (
    input logic                adcClk,
    input logic                rst,
    input logic                dataValid,
    input logic                full,
    input logic                armed,
    input acqDataPkg::ramWrite ramPort,
    input logic                rdReq,
    input logic                rdValid
);

    // A finished capture is never still waiting for its trigger
    fullNotArmed: assert property (@(posedge adcClk) disable iff (rst) !(full && armed))
        else $error("full and armed are both high");

    // A read asked for in a write cycle gets no data and keeps asking
    readHeldByWrite: assert property (@(posedge adcClk) disable iff (rst)
        rdReq && ramPort.enable |=> rdReq && !rdValid)
        else $error("read was not held off by a write");

    //////////////////////////////////////////////////////////////////////
    // Buffer writes follow valid input words through the detector pipeline

    writeAddrOnValid: assert property (@(posedge adcClk) disable iff (rst)
        ramPort.address != $past(ramPort.address) |->
            $past(dataValid, `DETECT_LATENCY))
        else $error("write address moved without a valid input word");

endmodule

bind acquisitionTop acquisitionChk acquisitionChk_i (
    .adcClk(adcClk),
    .rst(rst),
    .dataValid(dataValid),
    .full(full),
    .armed(armed),
    .ramPort(ramPort),
    .rdReq(rdReq),
    .rdValid(rdValid)
);

/* dv/acquisitionTb.sv */
/*
 * ADC capture block testbench
 * Ramp stimulus with level, falling edge and event triggers plus readback
 */
`timescale 1ns/1ps
`include "acq_defs.svh"

module acquisitionTb;

    localparam int numTests = 6;
    localparam int pretrig  = 8;
    localparam int rampTop  = 4000;

    logic                          adcClk, rst, csrStrobe, trigCfgStrobe, pretrigStrobe;
    logic                          dataValid;
    acqCfgPkg::hostWord            hostData;
    logic [`LANES*`SLOT_WIDTH-1:0] dataIn;
    logic [`EVENT_WIDTH-1:0]       eventStrobes;
    logic [31:0]                   status, sampleOut, triggerLocation;

    int errorCount, checkCount, wordIdx, firstWord, trigIdx, trigLaneExp;
    bit descending;

    acquisitionTop acquisitionTop_i (.*);

    // Lane k of word n on an ascending or descending ramp
    function automatic int rampValue(input int n, input int k);
        return descending ? rampTop - (4 * n + k) : 4 * n + k;
    endfunction

    function automatic logic [31:0] leftAdjusted(input int value);
        return 32'({`ADC_WIDTH'(value), {`ADC_SHIFT{1'b0}}});
    endfunction

    function automatic bit crosses(input int value, input int level, input bit falling);
        return falling ? value < level : value > level;
    endfunction

    // Advance one clock, drop strobes and present the next ramp word
    task automatic tick();
        @(posedge adcClk);
        #1;
        csrStrobe     = 1'b0;
        trigCfgStrobe = 1'b0;
        pretrigStrobe = 1'b0;
        eventStrobes  = '0;
        for (int k = 0; k < `LANES; k++) begin
            dataIn[k*`SLOT_WIDTH +: `SLOT_WIDTH] =
                `SLOT_WIDTH'(leftAdjusted(rampValue(wordIdx, k)));
        end
        wordIdx++;
    endtask

    task automatic checkValue(input string what, input logic [31:0] got,
                              input logic [31:0] expected);
        checkCount++;
        if (got !== expected) begin
            errorCount++;
            $display("Mismatch at %0d ns: %s is %0h, expected %0h", $time, what, got, expected);
        end
    endtask

    task automatic waitForFull();
        int cycles;
        cycles = 0;
        while (!status[30] && cycles < 4 * `RAM_DEPTH) begin
            tick();
            cycles++;
        end
        if (!status[30]) begin
            errorCount++;
            $display("Capture never completed, full stayed low at %0d ns", $time);
        end
    endtask

    task automatic startCapture(input int level, input bit falling, input int enables);
        wordIdx = 0;
        tick();
        hostData                   = '0;
        hostData.trig.level        = `ADC_WIDTH'(level);
        hostData.trig.fallingEdge  = falling;
        hostData.trig.eventEnables = `EVENT_WIDTH'(enables);
        trigCfgStrobe = 1'b1;
        tick();
        hostData.raw  = 32'(pretrig);
        pretrigStrobe = 1'b1;
        tick();
        hostData           = '0;
        hostData.ctrl.start = 1'b1;
        csrStrobe          = 1'b1;
        // First captured word is the one ahead of the start strobe
        firstWord = wordIdx - 2;
        tick();
        tick();
        checkValue("active two cycles after start", 32'(status[31]), 32'd1);
    endtask

    // First crossing word once armed and after an idle word
    task automatic predictTrigger(input int level, input bit falling);
        bit idle;
        int flags;
        idle    = 1'b0;
        trigIdx = -1;
        for (int n = pretrig + `DETECT_LATENCY - 1; n < `RAM_DEPTH && trigIdx < 0; n++) begin
            flags = 0;
            for (int k = `LANES - 1; k >= 0; k--) begin
                if (crosses(rampValue(firstWord + n, k), level, falling)) begin
                    flags++;
                    trigLaneExp = k;
                end
            end
            if (flags == 0) begin
                idle = 1'b1;
            end else if (idle) begin
                trigIdx = n;
            end
        end
    endtask

    task automatic readSample(input int address, input int lane, output logic [31:0] value);
        hostData                  = '0;
        hostData.ctrl.readAddress = `RAM_ADDR_WIDTH'(address);
        hostData.ctrl.readLane    = `LANE_SEL_WIDTH'(lane);
        csrStrobe = 1'b1;
        repeat (3) tick();
        value = sampleOut;
    endtask

    task automatic resetStatus();
        checkValue("status after reset", status, 32'h0);
    endtask

    task automatic levelTriggerCapture(input bit falling);
        int level;
        descending = falling;
        level = 4 * (pretrig + 12) + int'($urandom % 96);
        if (falling) begin
            level = rampTop - level;
        end
        startCapture(level, falling, 0);
        predictTrigger(level, falling);
        waitForFull();
        checkValue("status when done", status, {1'b0, 1'b1, 27'd0, 3'd4});
        checkValue("trigger location", triggerLocation,
                   32'((((trigIdx + `DETECT_LATENCY) % `RAM_DEPTH) << `LANE_SEL_WIDTH)
                       + trigLaneExp));
    endtask

    task automatic triggerSampleReadback();
        logic [31:0] value;
        readSample(int'(triggerLocation[7:2]), int'(triggerLocation[1:0]), value);
        checkValue("trigger sample", value, leftAdjusted(rampValue(firstWord + trigIdx,
                                                                   trigLaneExp)));
    endtask

    // Reads every slot relative to the trigger and wraps through the pretrigger words
    task automatic bufferReadback();
        logic [31:0] value;
        int          rel;
        int          trigAddr;
        trigAddr = (trigIdx + `DETECT_LATENCY) % `RAM_DEPTH;
        for (int a = 0; a < `RAM_DEPTH; a++) begin
            for (int k = 0; k < `LANES; k++) begin
                readSample(a, k, value);
                rel = (a - trigAddr + `RAM_DEPTH) % `RAM_DEPTH;
                rel = (trigIdx + rel) % `RAM_DEPTH;
                checkValue("buffer sample", value, leftAdjusted(rampValue(firstWord + rel, k)));
            end
        end
    endtask

    task automatic eventTriggerCapture();
        int cycles;
        descending = 1'b0;
        startCapture(8191, 1'b0, 8);
        cycles = 0;
        while (status[2:0] != 3'd2 && cycles < 4 * `RAM_DEPTH) begin
            tick();
            cycles++;
        end
        if (status[2:0] != 3'd2) begin
            errorCount++;
            $display("Capture never armed before the event strobe at %0d ns", $time);
        end
        eventStrobes[3] = 1'b1;
        tick();
        waitForFull();
        checkValue("event trigger lane", 32'(triggerLocation[1:0]), 32'd0);
        checkValue("full after event", 32'(status[30]), 32'd1);
    endtask

    initial begin
        adcClk = 1'b0;
        forever #5 adcClk = ~adcClk;
    end

    initial begin
        #(20 * `RAM_DEPTH * 10 * numTests);
        $display("Watchdog expired, the tests did not finish in time");
        $display("TB FAILED");
        $finish;
    end

    initial begin
        void'($urandom(32'h479f));
        rst = 1'b1;
        csrStrobe = 1'b0;
        trigCfgStrobe = 1'b0;
        pretrigStrobe = 1'b0;
        dataValid = 1'b1;
        hostData = '0;
        dataIn = '0;
        eventStrobes = '0;
        descending = 1'b0;
        wordIdx = 0;
        errorCount = 0;
        checkCount = 0;
        repeat (10) tick();
        rst = 1'b0;
        tick();
        resetStatus();
        levelTriggerCapture(1'b0);
        triggerSampleReadback();
        bufferReadback();
        levelTriggerCapture(1'b1);
        eventTriggerCapture();
        $display("Checks run %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* build.f */
+incdir+source
source/acqCfgPkg.sv
source/acqDataPkg.sv
source/acqConfigRegs.sv
source/triggerDetect.sv
source/acqSequencer.sv
source/sampleRamArbiter.sv
source/readoutPort.sv
source/acquisitionTop.sv
dv/acquisition_chk.sv
dv/acquisitionTb.sv

/* run.sh */
#!/usr/bin/env bash
# Compile the capture block testbench with Verilator, run it, check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps -f build.f \
    --top-module acquisitionTb -o acquisitionSim \
    && ./obj_dir/acquisitionSim > sim.log 2>&1 \
    || { echo "Build or simulation did not complete"; }
cat sim.log 2>/dev/null
grep -q "^TB PASSED$" sim.log && exit 0 || exit 1
